// ==== sources.f ====
+incdir+include
rtl/lc4_pkg.sv
rtl/lc4_regfile.sv
rtl/lc4_decode_stage.sv
rtl/lc4_execute_stage.sv
rtl/lc4_memory_stage.sv
rtl/lc4_writeback_stage.sv
rtl/lc4_pipeline.sv
sim/lc4_properties.sv
sim/lc4_checker.sv
sim/lc4_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the LC4 pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module lc4_tb \
  -f sources.f --Mdir obj_dir -o lc4_sim

./obj_dir/lc4_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "sim passed" sim.log; then
  exit 0
fi
exit 1

// ==== sim/lc4_tb.sv ====
/* LC4 pipeline testbench
   Clock, reset, LFSR instruction streams, data memory model and test sequence */
`timescale 1ns/100ps
`include "lc4_consts.svh"

module lc4_tb;
  import lc4_pkg::*;

  localparam int N_INSN = 40 + 54 + 60 + 40 + 10;   // Sum over tests 2..6

  logic          gwe;
  logic          rst_n;
  logic          insn_valid;
  logic [15:0]   insn;
  logic          insn_ready;
  lc4_dmem_req_t dmem;
  logic [15:0]   dmem_rdata;
  lc4_wb_t       wb;
  logic [31:0]   lfsr = 32'h17ce_0550;
  logic [15:0]   data_mem [logic [15:0]];
  int            wr_count = 0;
  int            errors;
  int            checks;
  int            pending;
  int            tb_errors = 0;

  lc4_pipeline DUT (
    .gwe (gwe), .i_rst_n (rst_n), .i_insn_valid (insn_valid), .i_insn (insn),
    .o_insn_ready (insn_ready), .o_dmem (dmem), .i_dmem_rdata (dmem_rdata), .o_wb (wb)
  );

  lc4_checker u_checker (
    .gwe (gwe), .i_rst_n (rst_n), .i_insn_valid (insn_valid), .i_insn (insn),
    .i_insn_ready (insn_ready), .i_dmem (dmem), .i_wb (wb),
    .o_errors (errors), .o_checks (checks), .o_pending (pending)
  );

  initial gwe = 1'b0;
  always #50 gwe = ~gwe;   // 100 ns period

  // Sparse memory, combinational read, write at rising edge
  function automatic logic [15:0] read_mem(input logic [15:0] a);
    if (data_mem.exists(a)) return data_mem[a];
    return {a[7:0], a[15:8]} ^ 16'h5ac3;
  endfunction

  always @(posedge gwe) begin
    if (dmem.we) begin
      data_mem[dmem.addr] = dmem.wdata;
      wr_count++;
    end
  end

  always @(dmem or wr_count) dmem_rdata = read_mem(dmem.addr);

  // Galois LFSR, one step per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = 16'h0000;
    for (int i = 0; i < n; i++) begin
      v    = {v[14:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic logic [15:0] enc_rrr(input logic [3:0] opc, input logic [1:0] sub,
                                          input logic [2:0] rd, input logic [2:0] rs,
                                          input logic [2:0] rt);
    return {opc, rd, rs, 1'b0, sub, rt};
  endfunction

  function automatic logic [15:0] random_alu();
    logic [15:0] k;
    logic [15:0] t;
    k = rand_bits(3);
    t = rand_bits(16);
    case (k[2:0])
      3'd0: return enc_rrr(`LC4_OPC_ARITH, 2'b00, t[2:0], t[5:3], t[8:6]);   // ADD
      3'd1: return enc_rrr(`LC4_OPC_ARITH, 2'b10, t[2:0], t[5:3], t[8:6]);   // SUB
      3'd2: return enc_rrr(`LC4_OPC_LOGIC, 2'b00, t[2:0], t[5:3], t[8:6]);
      3'd3: return enc_rrr(`LC4_OPC_LOGIC, 2'b10, t[2:0], t[5:3], t[8:6]);
      3'd4: return enc_rrr(`LC4_OPC_LOGIC, 2'b11, t[2:0], t[5:3], t[8:6]);
      3'd5: return {t[15] ? `LC4_OPC_LOGIC : `LC4_OPC_ARITH, t[2:0], t[5:3], 1'b1, t[13:9]};
      3'd6: return {`LC4_OPC_CONST, t[2:0], t[14:6]};
      default: return {`LC4_OPC_HICONST, t[2:0], 1'b1, t[13:6]};
    endcase
  endfunction

  // Encodings outside the subset, all must vanish
  function automatic logic [15:0] unsupported_insn();
    logic [15:0] k;
    logic [15:0] t;
    k = rand_bits(3);
    t = rand_bits(16);
    case (k[2:0])
      3'd0: return {4'b0000, t[11:0]};                             // Branch
      3'd1: return {4'b1100, t[11:0]};                             // JMP
      3'd2: return {4'b1111, t[11:0]};                             // TRAP
      3'd3: return {`LC4_OPC_ARITH, t[8:3], 3'b001, t[2:0]};       // MUL
      3'd4: return {`LC4_OPC_LOGIC, t[8:3], 3'b001, t[2:0]};       // NOT
      3'd5: return {`LC4_OPC_HICONST, t[2:0], 1'b0, t[10:3]};
      3'd6: return {4'b1010, t[11:0]};                             // Shifts
      default: return {4'b0010, t[11:0]};                          // CMP
    endcase
  endfunction

  task automatic send_insn(input logic [15:0] w);
    @(negedge gwe);
    insn_valid = 1'b1;
    insn       = w;
    while (!insn_ready) @(negedge gwe);   // Held through a stall
  endtask

  task automatic idle_cycles(input int n);
    @(negedge gwe);
    insn_valid = 1'b0;
    repeat (n - 1) @(negedge gwe);
  endtask

  task automatic drain_pipe();
    int waited;
    waited = 0;
    idle_cycles(1);
    while (pending != 0 && waited < 20) begin
      @(negedge gwe);
      waited++;
    end
    if (pending != 0) begin
      $display("ERROR %0d ns: %0d expected results never came out", $time, pending);
      tb_errors++;
    end
    repeat (5) @(negedge gwe);   // Room for stray writebacks
  endtask

  task automatic finish_test(input string name, input int start);
    drain_pipe();
    $display("test %-10s %s (%0d errors)", name,
             (errors + tb_errors == start) ? "ok" : "BAD", errors + tb_errors - start);
  endtask

  initial begin
    int          mark;
    logic [15:0] w;
    logic [15:0] t;
    insn_valid = 1'b0;
    insn       = 16'h0000;
    rst_n      = 1'b0;
    repeat (8) @(posedge gwe);
    @(negedge gwe);
    rst_n = 1'b1;

    mark = 0;
    finish_test("reset", mark);

    mark = errors + tb_errors;
    repeat (40) send_insn(random_alu());
    finish_test("alu", mark);

    mark = errors + tb_errors;   // Producer, d-1 fillers, consumer
    for (int d = 1; d <= 3; d++) begin
      for (int n = 0; n < 6; n++) begin
        w = random_alu();
        send_insn(w);
        for (int f = 1; f < d; f++) begin
          t = rand_bits(9);
          send_insn({`LC4_OPC_CONST, w[11:9] + 3'(f), t[8:0]});
        end
        t = rand_bits(3);
        send_insn(enc_rrr(`LC4_OPC_ARITH, 2'b00, t[2:0], w[11:9], w[11:9]));
      end
    end
    finish_test("bypass", mark);

    mark = errors + tb_errors;
    for (int n = 0; n < 12; n++) begin
      t = rand_bits(16);
      send_insn({`LC4_OPC_CONST, 3'd1, t[8:0]});
      send_insn({`LC4_OPC_CONST, 3'd2, t[15:9], 2'b01});
      t = rand_bits(16);
      send_insn({`LC4_OPC_HICONST, 3'd2, 1'b1, t[7:0]});
      send_insn({`LC4_OPC_STR, 3'd2, 3'd1, t[13:8]});
      if (n[0]) t = rand_bits(16) << 8;   // Odd rounds read elsewhere
      send_insn({`LC4_OPC_LDR, 3'd3, 3'd1, t[13:8]});
    end
    finish_test("ldst", mark);

    mark = errors + tb_errors;
    for (int n = 0; n < 8; n++) begin
      t = rand_bits(16);
      send_insn({`LC4_OPC_CONST, 3'd1, t[8:0]});
      send_insn({`LC4_OPC_LDR, 3'd4, 3'd1, t[14:9]});
      send_insn(enc_rrr(`LC4_OPC_ARITH, 2'b00, 3'd5, 3'd4, 3'd2));   // Stalls one cycle
      t = rand_bits(16);
      send_insn({`LC4_OPC_LDR, 3'd6, 3'd1, t[5:0]});
      send_insn({`LC4_OPC_STR, 3'd6, 3'd1, t[11:6]});                // WM, no stall
    end
    finish_test("load_use", mark);

    mark = errors + tb_errors;
    for (int n = 0; n < 10; n++) begin
      idle_cycles(2);
      send_insn(unsupported_insn());
    end
    finish_test("nop", mark);

    $display("checks %0d, errors %0d", checks, errors + tb_errors);
    if (errors + tb_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // Watchdog sized from the instruction count
  initial begin
    #((N_INSN * 2 + 50) * 100);
    $display("watchdog expired, the run did not finish in time");
    $display("sim failed");
    $finish;
  end

endmodule

// ==== sim/lc4_checker.sv ====
/* LC4 pipeline checker
   Reference model of the ISA subset, in-order compare of writebacks, memory accesses and ready */
`timescale 1ns/100ps
`include "lc4_consts.svh"

module lc4_checker (
  input  logic                   gwe,
  input  logic                   i_rst_n,
  input  logic                   i_insn_valid,
  input  logic [`LC4_WORD_W-1:0] i_insn,
  input  logic                   i_insn_ready,
  input  lc4_pkg::lc4_dmem_req_t i_dmem,
  input  lc4_pkg::lc4_wb_t       i_wb,
  output int                     o_errors,
  output int                     o_checks,
  output int                     o_pending
);
  import lc4_pkg::*;

  typedef struct packed {
    lc4_op_e     op;
    logic [2:0]  rd;
    logic [2:0]  rs;
    logic [2:0]  rt;
    logic        rs_re;
    logic        rt_re;
    logic [15:0] imm;
  } ref_dec_t;

  typedef struct packed {
    logic [2:0]  rd;
    logic [15:0] data;
    logic [2:0]  nzp;
  } exp_wb_t;

  typedef struct packed {
    logic [15:0] addr;
    logic [15:0] data;
  } exp_st_t;

  logic [15:0] model_rf [8];
  logic [15:0] model_mem [logic [15:0]];   // Only written words, rest is fill
  exp_wb_t     wb_q [$];
  exp_st_t     st_q [$];
  logic [15:0] ld_q [$];                    // Load addresses in program order
  ref_dec_t    d_slot;                      // Model of what sits in D
  ref_dec_t    x_slot;                      // And in X, OP_NOP is a bubble
  ref_dec_t    dec;
  exp_wb_t     ew;
  exp_st_t     es;
  logic [15:0] ea;
  logic        exp_ready;

  // Same whole-address pattern the testbench memory returns
  function automatic logic [15:0] mem_fill(input logic [15:0] a);
    return {a[7:0], a[15:8]} ^ 16'h5ac3;
  endfunction

  function automatic logic [2:0] nzp_of(input logic [15:0] v);
    if (v[15]) return 3'b100;
    if (v == 16'h0000) return 3'b010;
    return 3'b001;
  endfunction

  // ISA decode, anything outside the subset is a NOP
  function automatic ref_dec_t decode_ref(input logic [15:0] w);
    ref_dec_t d;
    d    = '0;
    d.rd = w[11:9];
    d.rs = w[8:6];
    d.rt = w[2:0];
    case (w[15:12])
      `LC4_OPC_ARITH: begin
        if (w[5])               d.op = OP_ADDI;
        else if (w[4:3] == 2'b00) d.op = OP_ADD;
        else if (w[4:3] == 2'b10) d.op = OP_SUB;
      end
      `LC4_OPC_LOGIC: begin
        if (w[5])               d.op = OP_ANDI;
        else if (w[4:3] == 2'b00) d.op = OP_AND;
        else if (w[4:3] == 2'b10) d.op = OP_OR;
        else if (w[4:3] == 2'b11) d.op = OP_XOR;
      end
      `LC4_OPC_LDR: d.op = OP_LDR;
      `LC4_OPC_STR: begin
        d.op = OP_STR;
        d.rt = w[11:9];                     // Data register
      end
      `LC4_OPC_CONST: d.op = OP_CONST;
      `LC4_OPC_HICONST: begin
        if (w[8]) begin
          d.op = OP_HICONST;
          d.rs = w[11:9];
        end
      end
      default: ;
    endcase
    case (d.op)
      OP_ADDI, OP_ANDI: d.imm = {{11{w[4]}}, w[4:0]};
      OP_LDR, OP_STR:   d.imm = {{10{w[5]}}, w[5:0]};
      OP_CONST:         d.imm = {{7{w[8]}}, w[8:0]};
      OP_HICONST:       d.imm = {8'h00, w[7:0]};
      default:          d.imm = 16'h0000;
    endcase
    d.rs_re = (d.op != OP_NOP) && (d.op != OP_CONST);
    d.rt_re = d.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_STR};
    return d;
  endfunction

  // Load in X blocks a reader in D, store data excepted
  function automatic logic load_use(input ref_dec_t x, input ref_dec_t d);
    return (x.op == OP_LDR) &&
           ((d.rs_re && (d.rs == x.rd)) || (d.rt_re && (d.op != OP_STR) && (d.rt == x.rd)));
  endfunction

  // Executes one instruction in program order and queues what it must produce
  function automatic void execute_ref(input ref_dec_t d);
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] r;
    logic [15:0] addr;
    exp_wb_t     e;
    exp_st_t     s;
    a = model_rf[d.rs];
    b = model_rf[d.rt];
    case (d.op)
      OP_ADD:           r = a + b;
      OP_SUB:           r = a - b;
      OP_ADDI, OP_STR:  r = a + d.imm;
      OP_AND:           r = a & b;
      OP_OR:            r = a | b;
      OP_XOR:           r = a ^ b;
      OP_ANDI:          r = a & d.imm;
      OP_CONST:         r = d.imm;
      OP_HICONST:       r = {d.imm[7:0], a[7:0]};
      OP_LDR: begin
        addr = a + d.imm;
        r    = model_mem.exists(addr) ? model_mem[addr] : mem_fill(addr);
        ld_q.push_back(addr);
      end
      default:          r = 16'h0000;
    endcase
    if (d.op == OP_STR) begin
      s.addr = r;
      s.data = b;
      model_mem[r] = b;
      st_q.push_back(s);
    end else if (d.op != OP_NOP) begin
      model_rf[d.rd] = r;
      e.rd   = d.rd;
      e.data = r;
      e.nzp  = nzp_of(r);
      wb_q.push_back(e);
    end
  endfunction

  task automatic report_value(input string sig, input logic [15:0] exp, input logic [15:0] act);
    $display("[FAIL] %0d ns %s expected %h got %h", $time, sig, exp, act);
    o_errors++;
  endtask

  always @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 8; i++) model_rf[i] = 16'h0000;
      model_mem.delete();
      wb_q.delete();
      st_q.delete();
      ld_q.delete();
      d_slot    = '0;
      x_slot    = '0;
      o_errors  = 0;
      o_checks  = 0;
      o_pending = 0;
    end else begin
      exp_ready = !load_use(x_slot, d_slot);
      o_checks++;
      if (i_insn_ready !== exp_ready) report_value("o_insn_ready", {15'b0, exp_ready},
                                                   {15'b0, i_insn_ready});
      if (i_wb.valid) begin
        if (wb_q.size() == 0) begin
          $display("ERROR %0d ns: writeback to r%0d with no instruction owing one", $time, i_wb.rd);
          o_errors++;
        end else begin
          ew = wb_q.pop_front();
          if (i_wb.rd !== ew.rd)     report_value("o_wb.rd", {13'b0, ew.rd}, {13'b0, i_wb.rd});
          if (i_wb.data !== ew.data) report_value("o_wb.data", ew.data, i_wb.data);
          if (i_wb.nzp !== ew.nzp)   report_value("o_wb.nzp", {13'b0, ew.nzp}, {13'b0, i_wb.nzp});
        end
      end
      if (i_dmem.we) begin
        if (st_q.size() == 0) begin
          $display("ERROR %0d ns: store to %h with no store instruction pending", $time,
                   i_dmem.addr);
          o_errors++;
        end else begin
          es = st_q.pop_front();
          if (i_dmem.addr !== es.addr)  report_value("o_dmem.addr", es.addr, i_dmem.addr);
          if (i_dmem.wdata !== es.data) report_value("o_dmem.wdata", es.data, i_dmem.wdata);
        end
      end
      if (i_dmem.re) begin
        if (ld_q.size() == 0) begin
          $display("ERROR %0d ns: read of %h with no load instruction pending", $time,
                   i_dmem.addr);
          o_errors++;
        end else begin
          ea = ld_q.pop_front();
          if (i_dmem.addr !== ea) report_value("o_dmem.addr", ea, i_dmem.addr);
        end
      end
      // Advance the occupancy model across this edge
      if (exp_ready) begin
        x_slot = d_slot;
        if (i_insn_valid) begin
          dec = decode_ref(i_insn);
          execute_ref(dec);
          d_slot = dec;
        end else begin
          d_slot = '0;
        end
      end else begin
        x_slot = '0;                        // Stall bubble, D holds
      end
      o_pending = wb_q.size() + st_q.size() + ld_q.size();
    end
  end

endmodule

// ==== sim/lc4_properties.sv ====
/* LC4 pipeline properties
   Ready never drops twice in a row, quiet outputs after reset, idle address zero */
`timescale 1ns/100ps

module lc4_properties (
  input logic                   gwe,
  input logic                   i_rst_n,
  input logic                   i_ready,
  input lc4_pkg::lc4_wb_t       i_wb,
  input lc4_pkg::lc4_dmem_req_t i_dmem
);

  logic [2:0] edges_since_rst;   // Saturates at 4

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n)                  edges_since_rst <= 3'd0;
    else if (edges_since_rst != 3'd4) edges_since_rst <= edges_since_rst + 3'd1;
  end

  // Load-use stall lasts one cycle
  ready_single_drop: assert property (@(posedge gwe) disable iff (!i_rst_n)
    !i_ready |=> i_ready) else $error("ready low two cycles in a row");

  // First possible writeback follows the fourth edge, first store the third
  no_early_wb: assert property (@(posedge gwe) disable iff (!i_rst_n)
    (edges_since_rst < 3'd4) |-> !i_wb.valid) else $error("writeback too soon after reset");

  no_early_store: assert property (@(posedge gwe) disable iff (!i_rst_n)
    (edges_since_rst < 3'd3) |-> !i_dmem.we) else $error("store too soon after reset");

  idle_addr_zero: assert property (@(posedge gwe) disable iff (!i_rst_n)
    !(i_dmem.re || i_dmem.we) |-> (i_dmem.addr == 16'h0000)) else $error("idle address not zero");

endmodule

bind lc4_pipeline lc4_properties u_props (
  .gwe     (gwe),
  .i_rst_n (i_rst_n),
  .i_ready (o_insn_ready),
  .i_wb    (o_wb),
  .i_dmem  (o_dmem)
);

// ==== rtl/lc4_pipeline.sv ====
/* LC4 five-stage integer pipeline
   Instruction stream in, data memory port and writeback trace out */
`timescale 1ns/100ps
`include "lc4_consts.svh"

module lc4_pipeline (
  input  logic                   gwe,
  input  logic                   i_rst_n,
  input  logic                   i_insn_valid,
  input  logic [`LC4_WORD_W-1:0] i_insn,
  output logic                   o_insn_ready,
  output lc4_pkg::lc4_dmem_req_t o_dmem,
  input  logic [`LC4_WORD_W-1:0] i_dmem_rdata,
  output lc4_pkg::lc4_wb_t       o_wb
);
  import lc4_pkg::*;

  lc4_dx_t                dx;
  lc4_xm_t                xm;
  lc4_mw_t                mw;
  lc4_xload_t             x_load;    // X -> D, load-use check
  lc4_fwd_t               m_fwd;     // M -> X bypass
  logic [`LC4_REG_W-1:0]  rs_sel;
  logic [`LC4_REG_W-1:0]  rt_sel;
  logic [`LC4_WORD_W-1:0] rs_data;
  logic [`LC4_WORD_W-1:0] rt_data;

  // W result doubles as register write and WX/WM bypass source
  lc4_regfile u_regfile (
    .gwe       (gwe),         .i_rst_n   (i_rst_n),
    .i_rs_sel  (rs_sel),      .i_rt_sel  (rt_sel),
    .o_rs_data (rs_data),     .o_rt_data (rt_data),
    .i_wr_en   (o_wb.valid),  .i_wr_sel  (o_wb.rd),
    .i_wr_data (o_wb.data)
  );

  lc4_decode_stage u_decode (
    .gwe          (gwe),          .i_rst_n      (i_rst_n),
    .i_insn_valid (i_insn_valid), .i_insn       (i_insn),
    .o_insn_ready (o_insn_ready), .i_x_load     (x_load),
    .o_rs_sel     (rs_sel),       .o_rt_sel     (rt_sel),
    .i_rs_data    (rs_data),      .i_rt_data    (rt_data),
    .o_dx         (dx)
  );

  lc4_execute_stage u_execute (
    .gwe      (gwe),    .i_rst_n  (i_rst_n),
    .i_dx     (dx),     .i_m_fwd  (m_fwd),
    .i_w_fwd  (o_wb),   .o_x_load (x_load),
    .o_xm     (xm)
  );

  lc4_memory_stage u_memory (
    .gwe          (gwe),          .i_rst_n (i_rst_n),
    .i_xm         (xm),           .i_w_fwd (o_wb),
    .o_m_fwd      (m_fwd),        .o_dmem  (o_dmem),
    .i_dmem_rdata (i_dmem_rdata), .o_mw    (mw)
  );

  lc4_writeback_stage u_writeback (
    .gwe (gwe), .i_rst_n (i_rst_n),
    .i_mw (mw), .o_wb    (o_wb)
  );

endmodule

// ==== rtl/lc4_writeback_stage.sv ====
/* LC4 writeback stage
   W register, register write request and NZP generation */
`timescale 1ns/100ps
`include "lc4_consts.svh"

module lc4_writeback_stage (
  input  logic             gwe,
  input  logic             i_rst_n,
  input  lc4_pkg::lc4_mw_t i_mw,
  output lc4_pkg::lc4_wb_t o_wb
);
  import lc4_pkg::*;

  lc4_mw_t                w_q;
  logic [`LC4_WORD_W-1:0] wdata;

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) w_q <= '0;
    else          w_q <= i_mw;
  end

  // Loaded word arrives already muxed into data by M
  assign wdata = w_q.data;

  assign o_wb.valid = w_q.valid && w_q.rd_we;   // Stores and bubbles write nothing
  assign o_wb.rd    = w_q.rd;
  assign o_wb.data  = wdata;

  // N from sign, Z when all zero, P otherwise
  assign o_wb.nzp[2] = wdata[`LC4_WORD_W-1];
  assign o_wb.nzp[1] = (wdata == '0);
  assign o_wb.nzp[0] = !wdata[`LC4_WORD_W-1] && (|wdata);

endmodule

// ==== rtl/lc4_memory_stage.sv ====
/* LC4 memory stage
   M register, data-memory request and WM bypass of store data */
`timescale 1ns/100ps
`include "lc4_consts.svh"

module lc4_memory_stage (
  input  logic                   gwe,
  input  logic                   i_rst_n,
  input  lc4_pkg::lc4_xm_t       i_xm,
  input  lc4_pkg::lc4_wb_t       i_w_fwd,
  output lc4_pkg::lc4_fwd_t      o_m_fwd,
  output lc4_pkg::lc4_dmem_req_t o_dmem,
  input  logic [`LC4_WORD_W-1:0] i_dmem_rdata,
  output lc4_pkg::lc4_mw_t       o_mw
);
  import lc4_pkg::*;

  lc4_xm_t m_q;
  logic    is_load;
  logic    is_store;

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) m_q <= '0;
    else          m_q <= i_xm;
  end

  assign is_load  = m_q.valid && (m_q.op == OP_LDR);
  assign is_store = m_q.valid && (m_q.op == OP_STR);

  assign o_dmem.re    = is_load;
  assign o_dmem.we    = is_store;
  assign o_dmem.addr  = (is_load || is_store) ? m_q.result : '0;   // Zero for non-memory ops
  // WM bypass, an ALU producer in W gives the same value MX already supplied
  assign o_dmem.wdata = (i_w_fwd.valid && (i_w_fwd.rd == m_q.rt)) ? i_w_fwd.data : m_q.st_data;

  // Load data is not ready in M, so loads are never forwarded from here
  assign o_m_fwd.valid = m_q.valid && m_q.rd_we && !is_load;
  assign o_m_fwd.rd    = m_q.rd;
  assign o_m_fwd.data  = m_q.result;

  assign o_mw.valid   = m_q.valid;
  assign o_mw.rd      = m_q.rd;
  assign o_mw.rd_we   = m_q.rd_we;
  assign o_mw.is_load = is_load;
  assign o_mw.data    = is_load ? i_dmem_rdata : m_q.result;

endmodule

// ==== rtl/lc4_execute_stage.sv ====
/* LC4 execute stage
   X register, MX/WX operand bypass and the integer ALU */
`timescale 1ns/100ps
`include "lc4_consts.svh"

module lc4_execute_stage (
  input  logic                gwe,
  input  logic                i_rst_n,
  input  lc4_pkg::lc4_dx_t    i_dx,
  input  lc4_pkg::lc4_fwd_t   i_m_fwd,
  input  lc4_pkg::lc4_wb_t    i_w_fwd,
  output lc4_pkg::lc4_xload_t o_x_load,
  output lc4_pkg::lc4_xm_t    o_xm
);
  import lc4_pkg::*;

  lc4_dx_t                x_q;
  logic [`LC4_WORD_W-1:0] op_a;   // rs after bypass
  logic [`LC4_WORD_W-1:0] op_b;   // rt after bypass
  logic [`LC4_WORD_W-1:0] alu;

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) x_q <= '0;
    else          x_q <= i_dx;
  end

  // Youngest producer wins: M, then W, else the value read in D
  function automatic logic [`LC4_WORD_W-1:0] bypass(
    input logic [`LC4_REG_W-1:0]  src,
    input logic [`LC4_WORD_W-1:0] rf_val,
    input lc4_fwd_t               m,
    input lc4_wb_t                w
  );
    if (m.valid && (m.rd == src)) return m.data;
    if (w.valid && (w.rd == src)) return w.data;
    return rf_val;
  endfunction

  assign op_a = bypass(x_q.uop.rs, x_q.rs_data, i_m_fwd, i_w_fwd);
  assign op_b = bypass(x_q.uop.rt, x_q.rt_data, i_m_fwd, i_w_fwd);

  always_comb begin
    case (x_q.uop.op)
      OP_ADD:                 alu = op_a + op_b;
      OP_SUB:                 alu = op_a - op_b;
      OP_ADDI, OP_LDR, OP_STR: alu = op_a + x_q.uop.imm;   // Also the memory address
      OP_AND:                 alu = op_a & op_b;
      OP_OR:                  alu = op_a | op_b;
      OP_XOR:                 alu = op_a ^ op_b;
      OP_ANDI:                alu = op_a & x_q.uop.imm;
      OP_CONST:               alu = x_q.uop.imm;
      OP_HICONST:             alu = {x_q.uop.imm[7:0], op_a[7:0]};  // Keep low byte of rd
      default:                alu = '0;
    endcase
  end

  // Load in X, checked by D for load-use
  assign o_x_load.valid = x_q.uop.valid && (x_q.uop.op == OP_LDR);
  assign o_x_load.rd    = x_q.uop.rd;

  assign o_xm.valid   = x_q.uop.valid;
  assign o_xm.op      = x_q.uop.op;
  assign o_xm.rd      = x_q.uop.rd;
  assign o_xm.rt      = x_q.uop.rt;
  assign o_xm.rd_we   = x_q.uop.rd_we;
  assign o_xm.result  = alu;
  assign o_xm.st_data = op_b;   // Still stale if a load is in M, fixed by WM

endmodule

// ==== rtl/lc4_decode_stage.sv ====
/* LC4 decode stage
   D register, instruction decode, operand read and load-use stall */
`timescale 1ns/100ps
`include "lc4_consts.svh"

module lc4_decode_stage (
  input  logic                   gwe,
  input  logic                   i_rst_n,
  input  logic                   i_insn_valid,
  input  logic [`LC4_WORD_W-1:0] i_insn,
  output logic                   o_insn_ready,
  input  lc4_pkg::lc4_xload_t    i_x_load,
  output logic [`LC4_REG_W-1:0]  o_rs_sel,
  output logic [`LC4_REG_W-1:0]  o_rt_sel,
  input  logic [`LC4_WORD_W-1:0] i_rs_data,
  input  logic [`LC4_WORD_W-1:0] i_rt_data,
  output lc4_pkg::lc4_dx_t       o_dx
);
  import lc4_pkg::*;

  logic                   d_valid;
  logic [`LC4_WORD_W-1:0] d_insn;
  logic [3:0]             opc;
  lc4_uop_t               uop;
  logic                   stall;

  // D register holds its word while stalled
  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      d_valid <= 1'b0;
      d_insn  <= `LC4_NOP_INSN;
    end else if (!stall) begin
      d_valid <= i_insn_valid;
      d_insn  <= i_insn_valid ? i_insn : `LC4_NOP_INSN;  // Gap becomes a bubble
    end
  end

  assign opc = d_insn[`LC4_OPC_MSB:`LC4_OPC_LSB];

  always_comb begin
    uop    = '0;
    uop.rd = d_insn[11:9];
    uop.rs = d_insn[8:6];
    uop.rt = d_insn[2:0];
    if (d_valid) begin
      case (opc)
        `LC4_OPC_ARITH: begin
          if (d_insn[5])                uop.op = OP_ADDI;
          else if (d_insn[4:3] == 2'b00) uop.op = OP_ADD;  // 001 is MUL, left out
          else if (d_insn[4:3] == 2'b10) uop.op = OP_SUB;
        end
        `LC4_OPC_LOGIC: begin
          if (d_insn[5])                uop.op = OP_ANDI;
          else if (d_insn[4:3] == 2'b00) uop.op = OP_AND;
          else if (d_insn[4:3] == 2'b10) uop.op = OP_OR;
          else if (d_insn[4:3] == 2'b11) uop.op = OP_XOR;
        end
        `LC4_OPC_LDR:   uop.op = OP_LDR;
        `LC4_OPC_STR: begin
          uop.op = OP_STR;
          uop.rt = d_insn[11:9];             // Store data register sits in the rd slot
        end
        `LC4_OPC_CONST: uop.op = OP_CONST;
        `LC4_OPC_HICONST: begin
          if (d_insn[8]) begin
            uop.op = OP_HICONST;
            uop.rs = d_insn[11:9];           // Reads its own destination
          end
        end
        default: ;                           // Anything else is a NOP
      endcase
    end
    case (uop.op)
      OP_ADDI, OP_ANDI: uop.imm = {{11{d_insn[4]}}, d_insn[4:0]};   // IMM5
      OP_LDR, OP_STR:   uop.imm = {{10{d_insn[5]}}, d_insn[5:0]};   // IMM6
      OP_CONST:         uop.imm = {{7{d_insn[8]}}, d_insn[8:0]};    // IMM9
      OP_HICONST:       uop.imm = {8'h00, d_insn[7:0]};             // UIMM8
      default:          uop.imm = '0;
    endcase
    uop.valid = (uop.op != OP_NOP);
    uop.rd_we = uop.valid && (uop.op != OP_STR);
    uop.rs_re = uop.valid && (uop.op != OP_CONST);
    uop.rt_re = uop.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_STR};
  end

  // Load in X feeding D, store data is excluded since WM covers it
  assign stall = i_x_load.valid &&
                 ((uop.rs_re && (uop.rs == i_x_load.rd)) ||
                  (uop.rt_re && (uop.op != OP_STR) && (uop.rt == i_x_load.rd)));

  assign o_insn_ready = !stall;
  assign o_rs_sel     = uop.rs;
  assign o_rt_sel     = uop.rt;

  always_comb begin
    o_dx.uop     = uop;
    if (stall) o_dx.uop = '0;                // Bubble into X
    o_dx.rs_data = i_rs_data;
    o_dx.rt_data = i_rt_data;
  end

endmodule

// ==== rtl/lc4_regfile.sv ====
/* LC4 register file
   Eight 16-bit registers, two read ports, one write port with write-through */
`timescale 1ns/100ps
`include "lc4_consts.svh"

module lc4_regfile (
  input  logic                   gwe,
  input  logic                   i_rst_n,
  input  logic [`LC4_REG_W-1:0]  i_rs_sel,
  input  logic [`LC4_REG_W-1:0]  i_rt_sel,
  output logic [`LC4_WORD_W-1:0] o_rs_data,
  output logic [`LC4_WORD_W-1:0] o_rt_data,
  input  logic                   i_wr_en,
  input  logic [`LC4_REG_W-1:0]  i_wr_sel,
  input  logic [`LC4_WORD_W-1:0] i_wr_data
);

  logic [`LC4_WORD_W-1:0] regs [`LC4_NREGS];

  always_ff @(posedge gwe or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < `LC4_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr_en) begin
      regs[i_wr_sel] <= i_wr_data;
    end
  end

  // Write-through: W result is visible to D in the same cycle (WD bypass)
  assign o_rs_data = (i_wr_en && (i_wr_sel == i_rs_sel)) ? i_wr_data : regs[i_rs_sel];
  assign o_rt_data = (i_wr_en && (i_wr_sel == i_rt_sel)) ? i_wr_data : regs[i_rt_sel];

endmodule

// ==== rtl/lc4_pkg.sv ====
/* LC4 pipeline types
   Decoded operation enum and the bundles passed between pipeline stages */
`include "lc4_consts.svh"

package lc4_pkg;

  // Decoded operation, OP_NOP must stay zero so a cleared uop is a bubble
  typedef enum logic [3:0] {
    OP_NOP, OP_ADD, OP_SUB, OP_ADDI,
    OP_AND, OP_OR, OP_XOR, OP_ANDI,
    OP_LDR, OP_STR, OP_CONST, OP_HICONST
  } lc4_op_e;

  typedef struct packed {
    logic                   valid;
    lc4_op_e                op;
    logic [`LC4_REG_W-1:0]  rd;
    logic [`LC4_REG_W-1:0]  rs;
    logic [`LC4_REG_W-1:0]  rt;
    logic                   rd_we;
    logic                   rs_re;
    logic                   rt_re;
    logic [`LC4_WORD_W-1:0] imm;     // Already extended
  } lc4_uop_t;

  typedef struct packed {
    lc4_uop_t               uop;
    logic [`LC4_WORD_W-1:0] rs_data;
    logic [`LC4_WORD_W-1:0] rt_data;
  } lc4_dx_t;

  typedef struct packed {
    logic                   valid;
    lc4_op_e                op;
    logic [`LC4_REG_W-1:0]  rd;
    logic [`LC4_REG_W-1:0]  rt;       // Store data source, for WM bypass
    logic                   rd_we;
    logic [`LC4_WORD_W-1:0] result;   // ALU value or memory address
    logic [`LC4_WORD_W-1:0] st_data;
  } lc4_xm_t;

  typedef struct packed {
    logic                   valid;
    logic [`LC4_REG_W-1:0]  rd;
    logic                   rd_we;
    logic                   is_load;
    logic [`LC4_WORD_W-1:0] data;     // ALU value or loaded word
  } lc4_mw_t;

  typedef struct packed {
    logic                   valid;    // Set only on a register write
    logic [`LC4_REG_W-1:0]  rd;
    logic [`LC4_WORD_W-1:0] data;
    logic [2:0]             nzp;
  } lc4_wb_t;

  typedef struct packed {
    logic                   re;
    logic                   we;
    logic [`LC4_WORD_W-1:0] addr;
    logic [`LC4_WORD_W-1:0] wdata;
  } lc4_dmem_req_t;

  // M-stage result offered to the X bypass
  typedef struct packed {
    logic                   valid;
    logic [`LC4_REG_W-1:0]  rd;
    logic [`LC4_WORD_W-1:0] data;
  } lc4_fwd_t;

  // Load sitting in X, used for load-use detection
  typedef struct packed {
    logic                  valid;
    logic [`LC4_REG_W-1:0] rd;
  } lc4_xload_t;

endpackage

// ==== include/lc4_consts.svh ====
/* LC4 ISA constants
   Word and register-file sizes, opcode field position and opcode values */
`ifndef LC4_CONSTS_SVH
`define LC4_CONSTS_SVH

// Datapath sizes, fixed by the ISA
`define LC4_WORD_W 16       // Data and instruction width
`define LC4_NREGS  8        // Architected registers R0..R7
`define LC4_REG_W  3        // Register select width

// Opcode field insn[15:12]
`define LC4_OPC_MSB 15
`define LC4_OPC_LSB 12

// Opcodes handled by this core
`define LC4_OPC_ARITH   4'b0001   // ADD/SUB/ADDI, subop in [5:3]
`define LC4_OPC_LOGIC   4'b0101   // AND/OR/XOR/ANDI
`define LC4_OPC_LDR     4'b0110
`define LC4_OPC_STR     4'b0111
`define LC4_OPC_CONST   4'b1001
`define LC4_OPC_HICONST 4'b1101

// Filler word for empty D slot
// Opcode 0000 is a never-taken branch, decodes as NOP here
`define LC4_NOP_INSN 16'h0000

`endif
